// ==== hw/arbPkg.sv ====
`default_nettype none

package arbPkg;

  // Number of requesters sharing the arbiter
  localparam int unsigned LineCnt = 4;

  // Width of the data word each requester offers
  localparam int unsigned DataWidth = 8;

  // Anti-glitch depth used when the top level is not overridden
  localparam int unsigned FilterLenDef = 3;

  // Bits needed to name one line
  localparam int unsigned LineIdxWidth = $clog2(LineCnt);

  // One bit per line, used for requests, grants and the pointer
  typedef logic [LineCnt-1:0] lineMaskT;

  // Index of a single line
  typedef logic [LineIdxWidth-1:0] lineIdxT;

  // Data word of one requester
  typedef logic [DataWidth-1:0] dataWordT;

  // All requesters' data words, line 0 in the lowest slot
  typedef dataWordT [LineCnt-1:0] lineDataT;

  // Grant result as seen by the consumer
  typedef struct packed {
    logic     valid;
    lineIdxT  idx;
    dataWordT data;
  } grantInfoT;

endpackage

`default_nettype wire

// ==== hw/reqDeglitch.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqDeglitch #(
  parameter int FilterLen = 3
) (
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::lineMaskT Req,
  output arbPkg::lineMaskT ReqClean
);

  import arbPkg::*;

  // Sample history per line, newest sample in bit 0
  logic [LineCnt-1:0][FilterLen-1:0] reqHist;
  logic [LineCnt-1:0][FilterLen-1:0] reqHistNext;

  // Held filter outputs
  lineMaskT cleanQ;
  lineMaskT cleanNext;

  // Per-line summary of the history
  lineMaskT histAllHigh;
  lineMaskT histAnyHigh;

  always_comb
  begin
    for (int line = 0; line < LineCnt; line++)
    begin
      reqHistNext[line] = {reqHist[line][FilterLen-2:0], Req[line]};
      histAllHigh[line] = &reqHist[line];
      histAnyHigh[line] = |reqHist[line];
    end
  end

  // Set on an all-high history, clear on all-low, otherwise hold
  always_comb
  begin
    for (int line = 0; line < LineCnt; line++)
    begin
      cleanNext[line] = histAllHigh[line] | (histAnyHigh[line] & cleanQ[line]);
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      reqHist <= '0;
      cleanQ  <= '0;
    end
    else
    begin
      reqHist <= reqHistNext;
      cleanQ  <= cleanNext;
    end
  end

  assign ReqClean = cleanQ;

endmodule

`default_nettype wire

// ==== hw/rrArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rrArbiter (
  input  logic             AClkB,
  input  logic             AResetBN,
  input  arbPkg::lineMaskT ReqClean,
  output arbPkg::lineMaskT Grant,
  output arbPkg::lineMaskT GrantNext
);

  import arbPkg::*;

  // One-hot priority pointer and the registered grant
  lineMaskT ptrQ;
  lineMaskT ptrNext;
  lineMaskT grantQ;

  // Requests seen from the pointer position
  lineMaskT reqRot;
  // Running OR of the rotated requests from bit 0 upward
  logic [LineCnt-2:0] reqRotSeen;
  // Lowest rotated request only
  lineMaskT reqRotLow;
  // Winner back in line order
  lineMaskT grantComb;

  logic reqAny;
  logic holderStays;

  // Rotate right by the pointer position
  always_comb
  begin
    reqRot = '0;
    for (int row = 0; row < LineCnt; row++)
    begin
      for (int col = 0; col < LineCnt; col++)
      begin
        reqRot[col] = reqRot[col] | (ptrQ[row] & ReqClean[(row + col) % LineCnt]);
      end
    end
  end

  // Keep only the first request at or above the pointer
  always_comb
  begin
    reqRotSeen[0] = reqRot[0];
    for (int col = 1; col < LineCnt - 1; col++)
    begin
      reqRotSeen[col] = reqRot[col] | reqRotSeen[col-1];
    end
    reqRotLow = reqRot & ~{reqRotSeen, 1'b0};
  end

  // Rotate the winner back left into line order
  always_comb
  begin
    grantComb = '0;
    for (int row = 0; row < LineCnt; row++)
    begin
      for (int col = 0; col < LineCnt; col++)
      begin
        grantComb[(row + col) % LineCnt] = grantComb[(row + col) % LineCnt] |
                                           (ptrQ[row] & reqRotLow[col]);
      end
    end
  end

  assign reqAny = |ReqClean;

  // Pointer stands still while the current holder keeps requesting
  assign holderStays = |(ReqClean & grantQ);

  always_comb
  begin
    if (reqAny && !holderStays)
    begin
      ptrNext = {ptrQ[LineCnt-2:0], ptrQ[LineCnt-1]};
    end
    else
    begin
      ptrNext = ptrQ;
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      ptrQ   <= lineMaskT'(1);
      grantQ <= '0;
    end
    else
    begin
      ptrQ   <= ptrNext;
      grantQ <= grantComb;
    end
  end

  assign Grant     = grantQ;
  assign GrantNext = grantComb;

endmodule

`default_nettype wire

// ==== hw/grantCapture.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantCapture (
  input  logic              AClkB,
  input  logic              AResetBN,
  input  arbPkg::lineMaskT  Grant,
  input  arbPkg::lineMaskT  GrantNext,
  input  arbPkg::lineDataT  ReqData,
  output arbPkg::grantInfoT GrantInfo
);

  import arbPkg::*;

  dataWordT  dataSel;
  dataWordT  dataNext;
  dataWordT  dataQ;
  logic      captureEn;
  lineIdxT   grantIdx;
  logic      grantValid;
  grantInfoT info;

  // AND-OR row select, GrantNext is one-hot or zero
  always_comb
  begin
    dataSel = '0;
    for (int line = 0; line < LineCnt; line++)
    begin
      dataSel = dataSel | (ReqData[line] & {DataWidth{GrantNext[line]}});
    end
  end

  assign captureEn = |GrantNext;

  // Last granted word survives while nothing is granted
  assign dataNext = captureEn ? dataSel : dataQ;

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      dataQ <= '0;
    end
    else
    begin
      dataQ <= dataNext;
    end
  end

  // One-hot to index, OR of the positions of the set bits
  always_comb
  begin
    grantIdx = '0;
    for (int line = 0; line < LineCnt; line++)
    begin
      grantIdx = grantIdx | (Grant[line] ? lineIdxT'(line) : lineIdxT'(0));
    end
  end

  assign grantValid = |Grant;

  always_comb
  begin
    info.valid = grantValid;
    info.idx   = grantIdx;
    info.data  = dataQ;
  end

  assign GrantInfo = info;

endmodule

`default_nettype wire

// ==== hw/reqArbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqArbTop #(
  parameter int FilterLen = arbPkg::FilterLenDef
) (
  input  logic              AClkB,
  input  logic              AResetBN,
  input  arbPkg::lineMaskT  Req,
  input  arbPkg::lineDataT  ReqData,
  output arbPkg::lineMaskT  Grant,
  output arbPkg::grantInfoT GrantInfo
);

  import arbPkg::*;

  // Debounced request levels
  lineMaskT reqClean;

  // Winner of the current cycle, before the grant register
  lineMaskT grantNext;

  reqDeglitch #(
    .FilterLen (FilterLen)
  ) u_reqDeglitch (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .Req      (Req),
    .ReqClean (reqClean)
  );

  rrArbiter u_rrArbiter (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .ReqClean  (reqClean),
    .Grant     (Grant),
    .GrantNext (grantNext)
  );

  // Data is taken at the same edge the grant loads
  grantCapture u_grantCapture (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .Grant     (Grant),
    .GrantNext (grantNext),
    .ReqData   (ReqData),
    .GrantInfo (GrantInfo)
  );

endmodule

`default_nettype wire

// ==== tests/grantChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantChecker #(
  parameter int FilterLen = 3
) (
  input  logic              AClkB,
  input  logic              AResetBN,
  input  arbPkg::lineMaskT  Req,
  input  arbPkg::lineDataT  ReqData,
  input  arbPkg::lineMaskT  Grant,
  input  arbPkg::grantInfoT GrantInfo,
  input  arbPkg::lineMaskT  ForbidMask,
  output int                ErrTotal,
  output int                FailedTests
);

  import arbPkg::*;

  // Model state, mirrors what the DUT holds after the latest rising edge
  logic [FilterLen-1:0] hist [LineCnt];
  lineMaskT cleanM;
  int       ptrM;
  lineMaskT grantM;
  dataWordT dataM;

  string curTest = "";
  int    errTotal = 0;
  int    startErrs = 0;
  int    testsRun = 0;
  int    failedTests = 0;

  assign ErrTotal    = errTotal;
  assign FailedTests = failedTests;

  task automatic resetModel();
    for (int line = 0; line < LineCnt; line++)
    begin
      hist[line] = '0;
    end
    cleanM = '0;
    ptrM   = 0;
    grantM = '0;
    dataM  = '0;
  endtask

  task automatic compareOutputs();
    grantInfoT expInfo;
    expInfo.valid = (grantM != '0);
    expInfo.idx   = '0;
    expInfo.data  = dataM;
    for (int line = 0; line < LineCnt; line++)
    begin
      if (grantM[line])
      begin
        expInfo.idx = lineIdxT'(line);
      end
    end
    if (Grant !== grantM)
    begin
      errTotal++;
      $display("ERR %s Grant expected %b actual %b", curTest, grantM, Grant);
    end
    if (GrantInfo !== expInfo)
    begin
      errTotal++;
      $display("ERR %s GrantInfo expected %h actual %h", curTest, expInfo, GrantInfo);
    end
    if ((Grant & ForbidMask) != '0)
    begin
      errTotal++;
      $display("%s: a line that only saw short pulses was granted (Grant %b)",
               curTest, Grant);
    end
  endtask

  // One rising edge of the arbiter, using the inputs the DUT samples next
  task automatic advanceModel();
    lineMaskT nextGrant;
    int       line;
    nextGrant = '0;
    for (int k = 0; k < LineCnt; k++)
    begin
      line = (ptrM + k) % LineCnt;
      if (nextGrant == '0 && cleanM[line])
      begin
        nextGrant[line] = 1'b1;
        dataM = ReqData[line];
      end
    end
    if (cleanM != '0 && (cleanM & grantM) == '0)
    begin
      ptrM = (ptrM + 1) % LineCnt;
    end
    for (int ln = 0; ln < LineCnt; ln++)
    begin
      if (&hist[ln])
      begin
        cleanM[ln] = 1'b1;
      end
      else if (hist[ln] == '0)
      begin
        cleanM[ln] = 1'b0;
      end
      hist[ln] = {hist[ln][FilterLen-2:0], Req[ln]};
    end
    grantM = nextGrant;
  endtask

  // Falling edge, outputs and driven inputs are both settled here
  always @(negedge AClkB)
  begin
    if (!AResetBN)
    begin
      resetModel();
    end
    compareOutputs();
    if (AResetBN)
    begin
      advanceModel();
    end
  end

  task automatic beginTest(input string name);
    curTest   = name;
    startErrs = errTotal;
  endtask

  task automatic endTest();
    int errs;
    errs = errTotal - startErrs;
    testsRun++;
    if (errs == 0)
    begin
      $display("%s: ok", curTest);
    end
    else
    begin
      failedTests++;
      $display("%s: failed with %0d mismatches", curTest, errs);
    end
  endtask

  task automatic printSummary();
    $display("Tests run %0d, failed %0d, mismatches %0d", testsRun, failedTests, errTotal);
  endtask

endmodule

`default_nettype wire

// ==== tests/reqArbTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module reqArbTb;

  import arbPkg::*;

  localparam int FilterLen     = FilterLenDef;
  localparam int ClkPeriod     = 4;
  localparam int ResetCycles   = 16;
  localparam int LenAfterReset = 24;
  localparam int LenGlitch     = 160;
  localparam int LenRoundRobin = 160;
  localparam int LenHold       = 64;
  localparam int LenRetain     = 48;
  localparam int LenRandom     = 400;
  localparam int TestCnt       = 6;
  localparam int Margin        = 200;
  localparam int TotalCycles   = ResetCycles + LenAfterReset + LenGlitch + LenRoundRobin +
                                 LenHold + LenRetain + LenRandom + TestCnt + Margin;

  logic      AClkB;
  logic      AResetBN;
  lineMaskT  req;
  lineDataT  reqData;
  lineMaskT  grant;
  grantInfoT grantInfo;
  lineMaskT  forbidMask;
  int        errTotal;
  int        failedTests;

  integer seed = 94186;

  // Current run of equal samples per line, for the pulse limiter
  int highRun [LineCnt];
  int lowRun [LineCnt];

  reqArbTop #(
    .FilterLen (FilterLen)
  ) u_reqArbTop (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .Req       (req),
    .ReqData   (reqData),
    .Grant     (grant),
    .GrantInfo (grantInfo)
  );

  grantChecker #(
    .FilterLen (FilterLen)
  ) u_grantChecker (
    .AClkB       (AClkB),
    .AResetBN    (AResetBN),
    .Req         (req),
    .ReqData     (reqData),
    .Grant       (grant),
    .GrantInfo   (grantInfo),
    .ForbidMask  (forbidMask),
    .ErrTotal    (errTotal),
    .FailedTests (failedTests)
  );

  initial
  begin
    AClkB = 1'b0;
    forever
    begin
      #(ClkPeriod / 2);
      AClkB = ~AClkB;
    end
  end

  task automatic nextCycle();
    @(posedge AClkB);
    #1;
  endtask

  task automatic randomizeData();
    for (int line = 0; line < LineCnt; line++)
    begin
      reqData[line] = dataWordT'($random(seed));
    end
  endtask

  function automatic int pickLine();
    return $unsigned($random(seed)) % LineCnt;
  endfunction

  // Random bit whose runs of the filtered level stay below FilterLen
  task automatic driveShortRuns(input int line, input logic keepHigh);
    logic bitVal;
    bitVal = 1'($random(seed));
    if (!keepHigh && highRun[line] >= FilterLen - 1)
    begin
      bitVal = 1'b0;
    end
    if (keepHigh && lowRun[line] >= FilterLen - 1)
    begin
      bitVal = 1'b1;
    end
    if (bitVal)
    begin
      highRun[line]++;
      lowRun[line] = 0;
    end
    else
    begin
      lowRun[line]++;
      highRun[line] = 0;
    end
    req[line] = bitVal;
  endtask

  task automatic runAfterReset();
    int line;
    line = pickLine();
    randomizeData();
    repeat (ResetCycles) @(posedge AClkB);
    #1;
    AResetBN = 1'b1;
    for (int cyc = 0; cyc < LenAfterReset; cyc++)
    begin
      nextCycle();
      req = (cyc < 4) ? lineMaskT'(0) : lineMaskT'(1) << line;
    end
  endtask

  task automatic runGlitch();
    int half;
    half = LenGlitch / 2;
    for (int line = 0; line < LineCnt; line++)
    begin
      highRun[line] = 0;
      lowRun[line]  = 0;
    end
    for (int cyc = 0; cyc < LenGlitch; cyc++)
    begin
      nextCycle();
      randomizeData();
      if (cyc < FilterLen + 4)
      begin
        req = '0;
      end
      else if (cyc < half)
      begin
        forbidMask = '1;
        for (int line = 0; line < LineCnt; line++)
        begin
          driveShortRuns(line, 1'b0);
        end
      end
      else
      begin
        // Line 0 held with short dropouts, the others only pulse
        forbidMask = ~lineMaskT'(1);
        if (cyc < half + FilterLen + 2)
        begin
          req[0]    = 1'b1;
          lowRun[0] = 0;
        end
        else
        begin
          driveShortRuns(0, 1'b1);
        end
        for (int line = 1; line < LineCnt; line++)
        begin
          driveShortRuns(line, 1'b0);
        end
      end
    end
    nextCycle();
    forbidMask = '0;
  endtask

  task automatic runRoundRobin();
    int stretch [LineCnt];
    req = '1;
    for (int line = 0; line < LineCnt; line++)
    begin
      stretch[line] = FilterLen + 1 + $unsigned($random(seed)) % 8;
    end
    for (int cyc = 0; cyc < LenRoundRobin; cyc++)
    begin
      nextCycle();
      randomizeData();
      for (int line = 0; line < LineCnt; line++)
      begin
        stretch[line]--;
        if (stretch[line] == 0)
        begin
          req[line]     = ~req[line];
          stretch[line] = FilterLen + 1 + $unsigned($random(seed)) % 8;
        end
      end
    end
  endtask

  task automatic runHold();
    for (int cyc = 0; cyc < LenHold; cyc++)
    begin
      nextCycle();
      randomizeData();
      req = '1;
      // Release lines one after another in the second half
      for (int line = 0; line < LineCnt; line++)
      begin
        if (cyc >= 32 + 8 * line)
        begin
          req[line] = 1'b0;
        end
      end
    end
  endtask

  task automatic runRetain();
    int line;
    line = pickLine();
    for (int cyc = 0; cyc < LenRetain; cyc++)
    begin
      nextCycle();
      randomizeData();
      req = (cyc < LenRetain / 2) ? lineMaskT'(1) << line : lineMaskT'(0);
    end
  endtask

  task automatic runRandom();
    for (int cyc = 0; cyc < LenRandom; cyc++)
    begin
      nextCycle();
      randomizeData();
      req = lineMaskT'($random(seed));
    end
  endtask

  initial
  begin
    AResetBN   = 1'b0;
    req        = '0;
    reqData    = '0;
    forbidMask = '0;
    u_grantChecker.beginTest("afterReset");
    runAfterReset();
    nextCycle();
    u_grantChecker.endTest();
    u_grantChecker.beginTest("glitchRejection");
    runGlitch();
    u_grantChecker.endTest();
    u_grantChecker.beginTest("roundRobinOrder");
    runRoundRobin();
    nextCycle();
    u_grantChecker.endTest();
    u_grantChecker.beginTest("holdWhileRequesting");
    runHold();
    nextCycle();
    u_grantChecker.endTest();
    u_grantChecker.beginTest("dataRetention");
    runRetain();
    nextCycle();
    u_grantChecker.endTest();
    u_grantChecker.beginTest("fullRandom");
    runRandom();
    nextCycle();
    u_grantChecker.endTest();
    u_grantChecker.printSummary();
    if (errTotal == 0 && failedTests == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial
  begin
    #(TotalCycles * ClkPeriod);
    $display("Watchdog timeout, the tests did not finish within %0d cycles", TotalCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== reqArb.f ====
hw/arbPkg.sv
hw/reqDeglitch.sv
hw/rrArbiter.sv
hw/grantCapture.sv
hw/reqArbTop.sv
tests/grantChecker.sv
tests/reqArbTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := reqArbTb
FILELIST  := reqArb.f
OBJDIR    := obj_dir
PASS_TEXT := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
